// ==== source/basic_block.sv ====
`default_nettype none

module basic_block
    import regex_pkg::*;
#(
    parameter int FIFO_COUNT_WIDTH = 6
)(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        go,
    input  logic                        cur_is_even_character,
    input  logic [CHAR_WIDTH-1:0]       current_character,
    // threads in
    input  pc_token_t                   input_pc,
    input  logic                        input_pc_valid,
    output logic                        input_pc_ready,
    output logic [FIFO_COUNT_WIDTH-1:0] input_pc_latency,
    // threads out
    output pc_token_t                   output_pc,
    output logic                        output_pc_valid,
    input  logic                        output_pc_ready,
    // program memory
    output logic [PC_WIDTH-1:0]         memory_addr,
    output logic                        memory_valid,
    input  logic                        memory_ready,
    input  logic [INSTR_WIDTH-1:0]      memory_data,
    output logic                        accepts,
    output logic                        running
);
    // current character stream between fifos and cpu
    logic [PC_WIDTH-1:0] cur_pc;
    logic                cur_valid;
    logic                cur_ready;
    logic                cur_nonempty;
    logic                cpu_busy;

    // work left either queued or inside the cpu
    assign running = cur_nonempty || cpu_busy;

    char_fifo_pair #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) fifos (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .cur_is_even_character (cur_is_even_character),
        .go                    (go),
        .in_token              (input_pc),
        .in_valid              (input_pc_valid),
        .cur_ready             (cur_ready),
        .in_ready              (input_pc_ready),
        .cur_pc                (cur_pc),
        .cur_valid             (cur_valid),
        .cur_nonempty          (cur_nonempty),
        .latency               (input_pc_latency)
    );

    regex_cpu cpu (
        .clk               (clk),
        .rst_n             (rst_n),
        .current_character (current_character),
        .cur_pc            (cur_pc),
        .cur_valid         (cur_valid),
        .cur_ready         (cur_ready),
        .memory_addr       (memory_addr),
        .memory_valid      (memory_valid),
        .memory_ready      (memory_ready),
        .memory_data       (memory_data),
        .output_pc         (output_pc),
        .output_pc_valid   (output_pc_valid),
        .output_pc_ready   (output_pc_ready),
        .accepts           (accepts),
        .busy              (cpu_busy)
    );

endmodule

`default_nettype wire

// ==== source/char_fifo_pair.sv ====
`default_nettype none

module char_fifo_pair
    import regex_pkg::*;
#(
    parameter int FIFO_COUNT_WIDTH = 6
)(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cur_is_even_character,
    input  logic                        go,
    input  pc_token_t                   in_token,
    input  logic                        in_valid,
    input  logic                        cur_ready,
    output logic                        in_ready,
    output logic [PC_WIDTH-1:0]         cur_pc,
    output logic                        cur_valid,
    output logic                        cur_nonempty,
    output logic [FIFO_COUNT_WIDTH-1:0] latency
);
    // even fifo
    logic                        even_wr;
    logic                        even_rd;
    logic [PC_WIDTH-1:0]         even_dout;
    logic                        even_full;
    logic                        even_empty;
    logic [FIFO_COUNT_WIDTH-1:0] even_count;
    // odd fifo
    logic                        odd_wr;
    logic                        odd_rd;
    logic [PC_WIDTH-1:0]         odd_dout;
    logic                        odd_full;
    logic                        odd_empty;
    logic [FIFO_COUNT_WIDTH-1:0] odd_count;
    // current character view
    logic                        in_fire;
    logic                        cur_rd;
    logic                        cur_empty;
    logic [FIFO_COUNT_WIDTH-1:0] cur_count;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    // conservative ready avoids a loop through the token tag
    assign in_ready = !even_full && !odd_full;
    assign in_fire  = in_valid && in_ready;

    // even takes current tokens on even characters and next tokens on odd ones
    assign even_wr = in_fire && (in_token.to_current == cur_is_even_character);
    assign odd_wr  = in_fire && (in_token.to_current != cur_is_even_character);

    //////////////////////////////////////////////////////////////////////
    // current character side
    //////////////////////////////////////////////////////////////////////

    // go enables the dequeue toward the cpu
    assign cur_rd = go && cur_ready;

    // next fifo is only ever written
    assign even_rd = cur_is_even_character && cur_rd;
    assign odd_rd  = !cur_is_even_character && cur_rd;

    assign cur_pc    = cur_is_even_character ? even_dout  : odd_dout;
    assign cur_empty = cur_is_even_character ? even_empty : odd_empty;
    assign cur_count = cur_is_even_character ? even_count : odd_count;

    assign cur_nonempty = !cur_empty;
    assign cur_valid    = go && !cur_empty;

    // fill plus one for the thread itself, held at all ones
    assign latency = (&cur_count) ? cur_count : cur_count + 1'b1;

    pc_fifo #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) fifo_even (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (in_token.pc),
        .wr_en      (even_wr),
        .rd_en      (even_rd),
        .dout       (even_dout),
        .full       (even_full),
        .empty      (even_empty),
        .data_count (even_count)
    );

    pc_fifo #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) fifo_odd (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (in_token.pc),
        .wr_en      (odd_wr),
        .rd_en      (odd_rd),
        .dout       (odd_dout),
        .full       (odd_full),
        .empty      (odd_empty),
        .data_count (odd_count)
    );

endmodule

`default_nettype wire

// ==== source/pc_fifo.sv ====
`default_nettype none

module pc_fifo
    import regex_pkg::*;
#(
    parameter int FIFO_COUNT_WIDTH = 6
)(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [PC_WIDTH-1:0]         din,
    input  logic                        wr_en,
    input  logic                        rd_en,
    output logic [PC_WIDTH-1:0]         dout,
    output logic                        full,
    output logic                        empty,
    output logic [FIFO_COUNT_WIDTH-1:0] data_count
);
    // one slot less than the counter range so the count never wraps
    localparam int DEPTH = (1 << FIFO_COUNT_WIDTH) - 1;
    localparam logic [FIFO_COUNT_WIDTH-1:0] LAST_IDX = FIFO_COUNT_WIDTH'(DEPTH - 1);

    logic [PC_WIDTH-1:0]         mem [DEPTH];
    logic [FIFO_COUNT_WIDTH-1:0] wr_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] rd_ptr;
    logic                        do_wr;
    logic                        do_rd;

    // drop writes into a full buffer and reads from an empty one
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // flags come straight from the registered count
    assign full  = &data_count;
    assign empty = (data_count == '0);

    // head is read without a register stage
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            data_count <= '0;
        end
        else
        begin
            // pointers wrap at the last slot
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_wr, do_rd})
                2'b10:   data_count <= data_count + 1'b1;
                2'b01:   data_count <= data_count - 1'b1;
                default: data_count <= data_count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/regex_cpu.sv ====
`default_nettype none

module regex_cpu
    import regex_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [CHAR_WIDTH-1:0]  current_character,
    // thread in from the current fifo
    input  logic [PC_WIDTH-1:0]    cur_pc,
    input  logic                   cur_valid,
    output logic                   cur_ready,
    // program memory
    output logic [PC_WIDTH-1:0]    memory_addr,
    output logic                   memory_valid,
    input  logic                   memory_ready,
    input  logic [INSTR_WIDTH-1:0] memory_data,
    // threads out
    output pc_token_t              output_pc,
    output logic                   output_pc_valid,
    input  logic                   output_pc_ready,
    output logic                   accepts,
    output logic                   busy
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EMIT,
        S_EMIT_SECOND
    } state_t;

    state_t              state;
    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] pc_plus_one;
    logic [PC_WIDTH-1:0] target_q;
    pc_token_t           out_q;
    logic                split_q;
    instr_t              instr;
    logic                take_thread;
    logic                fetch_done;
    logic                out_fire;
    logic                char_hit;

    //////////////////////////////////////////////////////////////////////
    // handshakes and decode
    //////////////////////////////////////////////////////////////////////

    // one thread at a time
    assign cur_ready   = (state == S_IDLE);
    assign take_thread = cur_valid && cur_ready;

    // request held until memory answers
    assign memory_valid = (state == S_FETCH);
    assign memory_addr  = pc_q;
    assign fetch_done   = memory_valid && memory_ready;

    assign output_pc_valid = (state == S_EMIT) || (state == S_EMIT_SECOND);
    assign output_pc       = out_q;
    assign out_fire        = output_pc_valid && output_pc_ready;

    assign busy = (state != S_IDLE);

    // same word read as match or as branch
    assign instr       = memory_data;
    assign char_hit    = (instr.match.character == current_character);
    assign pc_plus_one = pc_q + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= S_IDLE;
            split_q <= 1'b0;
            accepts <= 1'b0;
        end
        else
        begin
            // single cycle pulse
            accepts <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (take_thread)
                    begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH:
                begin
                    // execute on the edge the word arrives
                    if (memory_ready)
                    begin
                        split_q <= 1'b0;
                        case (instr.match.opcode)
                            OP_MATCH:
                            begin
                                // a miss kills the thread
                                state <= char_hit ? S_EMIT : S_IDLE;
                            end
                            OP_JMP:
                            begin
                                state <= S_EMIT;
                            end
                            OP_SPLIT:
                            begin
                                state   <= S_EMIT;
                                split_q <= 1'b1;
                            end
                            OP_ACCEPT:
                            begin
                                accepts <= 1'b1;
                                state   <= S_IDLE;
                            end
                            default:
                            begin
                                state <= S_IDLE;
                            end
                        endcase
                    end
                end
                S_EMIT:
                begin
                    // split goes on to its target
                    if (output_pc_ready)
                    begin
                        state <= split_q ? S_EMIT_SECOND : S_IDLE;
                    end
                end
                S_EMIT_SECOND:
                begin
                    if (output_pc_ready)
                    begin
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // thread data
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (take_thread)
        begin
            pc_q <= cur_pc;
        end
        if (fetch_done)
        begin
            target_q <= instr.branch.target;
            // match moves on to the next character, branches stay on this one
            case (instr.match.opcode)
                OP_MATCH: out_q <= '{pc: pc_plus_one, to_current: 1'b0};
                OP_JMP:   out_q <= '{pc: instr.branch.target, to_current: 1'b1};
                default:  out_q <= '{pc: pc_plus_one, to_current: 1'b1};
            endcase
        end
        else if (out_fire && (state == S_EMIT))
        begin
            // second split token, unused when no split is pending
            out_q <= '{pc: target_q, to_current: 1'b1};
        end
    end

endmodule

`default_nettype wire

// ==== source/regex_pkg.sv ====
`default_nettype none

package regex_pkg;

    // thread program counter and memory address width
    parameter int PC_WIDTH    = 8;
    // input character width
    parameter int CHAR_WIDTH  = 8;
    // one instruction per memory word
    parameter int INSTR_WIDTH = 16;

    typedef enum logic [2:0] {
        OP_MATCH  = 3'd0,
        OP_JMP    = 3'd1,
        OP_SPLIT  = 3'd2,
        OP_ACCEPT = 3'd3
    } opcode_t;

    // character match view of an instruction word
    typedef struct packed {
        opcode_t               opcode;
        logic [4:0]            reserved;
        logic [CHAR_WIDTH-1:0] character;
    } instr_match_t;

    // branch view used by jmp and split
    typedef struct packed {
        opcode_t               opcode;
        logic [4:0]            reserved;
        logic [PC_WIDTH-1:0]   target;
    } instr_branch_t;

    typedef union packed {
        instr_match_t  match;
        instr_branch_t branch;
    } instr_t;

    // a thread, with the current/next tag in bit 0
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                to_current;
    } pc_token_t;

endpackage

`default_nettype wire

// ==== test/basic_block_props.sv ====
`default_nettype none

module basic_block_props
    import regex_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic [PC_WIDTH-1:0] memory_addr,
    input logic                memory_valid,
    input logic                memory_ready,
    input pc_token_t           output_pc,
    input logic                output_pc_valid,
    input logic                output_pc_ready,
    input logic                input_pc_ready,
    input logic                even_full,
    input logic                odd_full
);
    // failed assertion count, read by the testbench at the end
    int failures = 0;

    // request held until the memory answers
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        memory_valid && !memory_ready |=> memory_valid && $stable(memory_addr))
    else
    begin
        failures++;
        $error("memory request changed before memory_ready");
    end

    // token held while the sink stalls
    out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        output_pc_valid && !output_pc_ready |=> output_pc_valid && $stable(output_pc))
    else
    begin
        failures++;
        $error("output token changed under back-pressure");
    end

    full_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        (even_full || odd_full) |-> !input_pc_ready)
    else
    begin
        failures++;
        $error("input ready high with a full FIFO");
    end

endmodule

bind basic_block basic_block_props props (
    .clk             (clk),
    .rst_n           (rst_n),
    .memory_addr     (memory_addr),
    .memory_valid    (memory_valid),
    .memory_ready    (memory_ready),
    .output_pc       (output_pc),
    .output_pc_valid (output_pc_valid),
    .output_pc_ready (output_pc_ready),
    .input_pc_ready  (input_pc_ready),
    .even_full       (fifos.even_full),
    .odd_full        (fifos.odd_full)
);

`default_nettype wire

// ==== test/basic_block_tb.sv ====
`default_nettype none

module basic_block_tb
    import regex_pkg::*;
();
    localparam int FIFO_COUNT_WIDTH = 6;
    localparam int FIFO_MAX         = (1 << FIFO_COUNT_WIDTH) - 1;
    localparam int TIMEOUT_CYCLES   = 20000;

    logic                        clk;
    logic                        rst_n;
    logic                        go;
    logic                        cur_is_even_character;
    logic [CHAR_WIDTH-1:0]       current_character;
    pc_token_t                   input_pc;
    logic                        input_pc_valid;
    logic                        input_pc_ready;
    logic [FIFO_COUNT_WIDTH-1:0] input_pc_latency;
    pc_token_t                   output_pc;
    logic                        output_pc_valid;
    logic                        output_pc_ready;
    logic [PC_WIDTH-1:0]         memory_addr;
    logic                        memory_valid;
    logic                        memory_ready;
    logic [INSTR_WIDTH-1:0]      memory_data;
    logic                        accepts;
    logic                        running;

    // program copy for the reference model
    logic [INSTR_WIDTH-1:0] program_words [1 << PC_WIDTH];
    pc_token_t              exp_q [$];
    // tokens whose outputs are expected only after a parity swap
    pc_token_t              held_q [$];
    // thread pcs in the order the cpu fetches them
    logic [PC_WIDTH-1:0]    fetch_q [$];
    pc_token_t              exp_tok;
    logic [PC_WIDTH-1:0]    exp_addr;
    logic [CHAR_WIDTH-1:0]  test_char;
    logic                   random_ready;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int errors_base = 0;
    int exp_accepts = 0;
    int seen_accepts = 0;
    int cycle_count = 0;

    basic_block #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) UUT (
        .clk (clk), .rst_n (rst_n), .go (go),
        .cur_is_even_character (cur_is_even_character),
        .current_character (current_character),
        .input_pc (input_pc), .input_pc_valid (input_pc_valid),
        .input_pc_ready (input_pc_ready), .input_pc_latency (input_pc_latency),
        .output_pc (output_pc), .output_pc_valid (output_pc_valid),
        .output_pc_ready (output_pc_ready),
        .memory_addr (memory_addr), .memory_valid (memory_valid),
        .memory_ready (memory_ready), .memory_data (memory_data),
        .accepts (accepts), .running (running)
    );

    tb_program_mem mem_model (
        .clk (clk), .rst_n (rst_n), .addr (memory_addr), .valid (memory_valid),
        .ready (memory_ready), .data (memory_data)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [INSTR_WIDTH-1:0] encode_word(input opcode_t op,
                                                           input logic [7:0] arg);
        return {op, 5'b00000, arg};
    endfunction

    // one thread on one character gives up to two tokens and an accept flag
    function automatic void model_thread(input logic [INSTR_WIDTH-1:0] prog [1 << PC_WIDTH],
                                         input pc_token_t tok, input logic [7:0] ch,
                                         output pc_token_t tok_a, output pc_token_t tok_b,
                                         output int count, output bit accept);
        logic [INSTR_WIDTH-1:0] word;
        logic [2:0]             op;
        logic [7:0]             arg;
        word   = prog[tok.pc];
        op     = word[15:13];
        arg    = word[7:0];
        tok_a  = '0;
        tok_b  = '0;
        count  = 0;
        accept = 1'b0;
        case (op)
            OP_MATCH:
            begin
                // a hit moves on to the next character
                if (arg == ch)
                begin
                    tok_a = '{pc: PC_WIDTH'(tok.pc + 1), to_current: 1'b0};
                    count = 1;
                end
            end
            OP_JMP:
            begin
                tok_a = '{pc: arg, to_current: 1'b1};
                count = 1;
            end
            OP_SPLIT:
            begin
                tok_a = '{pc: PC_WIDTH'(tok.pc + 1), to_current: 1'b1};
                tok_b = '{pc: arg, to_current: 1'b1};
                count = 2;
            end
            OP_ACCEPT: accept = 1'b1;
            default:   count = 0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("[ERROR] %s: expected 0x%h got 0x%h", name, want, got);
        end
    endtask

    task automatic queue_expected(input pc_token_t tok, input logic [CHAR_WIDTH-1:0] ch);
        pc_token_t tok_a;
        pc_token_t tok_b;
        int        count;
        bit        accept;
        model_thread(program_words, tok, ch, tok_a, tok_b, count, accept);
        // every executed thread fetches its own pc once
        fetch_q.push_back(tok.pc);
        if (count > 0)
            exp_q.push_back(tok_a);
        if (count > 1)
            exp_q.push_back(tok_b);
        if (accept)
            exp_accepts++;
    endtask

    // valid held until the edge where ready is seen
    task automatic push_token(input pc_token_t tok);
        input_pc       <= tok;
        input_pc_valid <= 1'b1;
        @(posedge clk);
        while (!input_pc_ready)
            @(posedge clk);
        input_pc_valid <= 1'b0;
    endtask

    task automatic send_thread(input logic [PC_WIDTH-1:0] pc, input logic to_cur,
                               input bit defer);
        pc_token_t tok;
        tok.pc         = pc;
        tok.to_current = to_cur;
        if (defer)
            held_q.push_back(tok);
        else
            queue_expected(tok, test_char);
        push_token(tok);
    endtask

    task automatic release_held(input int n);
        repeat (n) queue_expected(held_q.pop_front(), test_char);
    endtask

    // running low means both the current FIFO and the cpu are empty
    task automatic wait_drain();
        repeat (2) @(posedge clk);
        while (running)
            @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected output tokens never arrived", exp_q.size());
            exp_q.delete();
        end
        if (fetch_q.size() != 0)
        begin
            errors++;
            $display("%0d expected instruction fetches never happened", fetch_q.size());
            fetch_q.delete();
        end
        compare_value("accepts count", seen_accepts, exp_accepts);
        exp_accepts  = 0;
        seen_accepts = 0;
        tests++;
        if (errors == errors_base)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_base);
        errors_base = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, timeout, sink and compare
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk)
        output_pc_ready <= random_ready ? (($urandom % 3) != 0) : 1'b1;

    always @(posedge clk)
    begin
        if (rst_n && output_pc_valid && output_pc_ready)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("unexpected output token with pc 0x%h", output_pc.pc);
            end
            else
            begin
                exp_tok = exp_q.pop_front();
                checks++;
                if (output_pc !== exp_tok)
                begin
                    errors++;
                    $display("[ERROR] output_pc: expected 0x%h got 0x%h", exp_tok, output_pc);
                end
            end
        end
        // address checked on the edge the word is handed over
        if (rst_n && memory_valid && memory_ready)
        begin
            if (fetch_q.size() == 0)
            begin
                errors++;
                $display("unexpected instruction fetch from address 0x%h", memory_addr);
            end
            else
            begin
                exp_addr = fetch_q.pop_front();
                checks++;
                if (memory_addr !== exp_addr)
                begin
                    errors++;
                    $display("[ERROR] memory_addr: expected 0x%h got 0x%h",
                             exp_addr, memory_addr);
                end
            end
        end
        if (rst_n && accepts)
            seen_accepts++;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int        n;
        pc_token_t tok;
        void'($urandom(32'hc228));
        rst_n                 = 1'b0;
        go                    = 1'b0;
        cur_is_even_character = 1'b1;
        current_character     = '0;
        input_pc              = '0;
        input_pc_valid        = 1'b0;
        output_pc_ready       = 1'b1;
        random_ready          = 1'b0;
        test_char             = 8'h61;
        // fill with matches on the address itself and then the fixed program
        for (int a = 0; a < (1 << PC_WIDTH); a++)
            program_words[a] = encode_word(OP_MATCH, CHAR_WIDTH'(a));
        program_words[8'h10] = encode_word(OP_MATCH, 8'h61);
        program_words[8'h11] = encode_word(OP_MATCH, 8'h62);
        program_words[8'h20] = encode_word(OP_JMP, 8'h40);
        program_words[8'h21] = encode_word(OP_SPLIT, 8'h30);
        program_words[8'h22] = encode_word(OP_ACCEPT, 8'h00);
        for (int a = 0; a < (1 << PC_WIDTH); a++)
            mem_model.mem[a] = program_words[a];

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        compare_value("output_pc_valid", output_pc_valid, 0);
        compare_value("memory_valid", memory_valid, 0);
        compare_value("accepts", accepts, 0);
        compare_value("running", running, 0);
        compare_value("input_pc_ready", input_pc_ready, 1);
        finish_test("reset state");

        go                <= 1'b1;
        current_character <= test_char;
        send_thread(8'h10, 1'b1, 1'b0);
        send_thread(8'h11, 1'b1, 1'b0);
        send_thread(8'h61, 1'b1, 1'b0);
        send_thread(8'h62, 1'b1, 1'b0);
        send_thread(8'h10, 1'b1, 1'b0);
        wait_drain();
        finish_test("match");

        random_ready <= 1'b1;
        send_thread(8'h21, 1'b1, 1'b0);
        send_thread(8'h20, 1'b1, 1'b0);
        send_thread(8'h22, 1'b1, 1'b0);
        send_thread(8'h21, 1'b1, 1'b0);
        wait_drain();
        finish_test("branches");

        // next-tagged threads sit in the odd FIFO while go is high
        random_ready <= 1'b0;
        send_thread(8'h11, 1'b0, 1'b1);
        send_thread(8'h20, 1'b0, 1'b1);
        send_thread(8'h62, 1'b0, 1'b1);
        send_thread(8'h63, 1'b0, 1'b1);
        repeat (20) @(posedge clk);
        compare_value("memory_valid", memory_valid, 0);
        compare_value("running", running, 0);
        go <= 1'b0;
        send_thread(8'h10, 1'b1, 1'b1);
        send_thread(8'h21, 1'b1, 1'b1);
        send_thread(8'h22, 1'b1, 1'b1);
        test_char              = 8'h62;
        current_character     <= test_char;
        cur_is_even_character <= 1'b0;
        go                    <= 1'b1;
        release_held(4);
        wait_drain();
        // even FIFO is next now, so its threads stay put
        repeat (20) @(posedge clk);
        compare_value("memory_valid", memory_valid, 0);
        test_char              = 8'h61;
        current_character     <= test_char;
        cur_is_even_character <= 1'b1;
        release_held(held_q.size());
        wait_drain();
        finish_test("parity swap");

        go           <= 1'b0;
        random_ready <= 1'b1;
        n = 0;
        compare_value("input_pc_latency", input_pc_latency, 1);
        while (input_pc_ready && n <= FIFO_MAX)
        begin
            tok.pc         = (n % 4 == 0) ? PC_WIDTH'(8'h20 + n % 3) : PC_WIDTH'($urandom);
            tok.to_current = 1'b1;
            queue_expected(tok, test_char);
            push_token(tok);
            @(posedge clk);
            n++;
            compare_value("input_pc_latency", input_pc_latency,
                          (n >= FIFO_MAX) ? FIFO_MAX : n + 1);
        end
        compare_value("fill count", n, FIFO_MAX);
        go <= 1'b1;
        wait_drain();
        finish_test("back-pressure and fill");

        if (UUT.props.failures != 0)
        begin
            errors += UUT.props.failures;
            $display("handshake assertions failed %0d times", UUT.props.failures);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_program_mem.sv ====
`default_nettype none

module tb_program_mem
    import regex_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [PC_WIDTH-1:0]    addr,
    input  logic                   valid,
    output logic                   ready,
    output logic [INSTR_WIDTH-1:0] data
);
    // program image, written by the testbench before reset ends
    logic [INSTR_WIDTH-1:0] mem [1 << PC_WIDTH];
    int unsigned            wait_left;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ready     <= 1'b0;
            data      <= '0;
            wait_left <= 0;
        end
        else if (ready)
        begin
            // word taken on this edge
            ready <= 1'b0;
        end
        else if (valid)
        begin
            if (wait_left == 0)
            begin
                ready <= 1'b1;
                data  <= mem[addr];
            end
            else
            begin
                wait_left <= wait_left - 1;
            end
        end
        else
        begin
            // 0 to 3 wait states for the next request
            wait_left <= $urandom % 4;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/regex_pkg.sv
source/pc_fifo.sv
source/char_fifo_pair.sv
source/regex_cpu.sv
source/basic_block.sv
test/tb_program_mem.sv
test/basic_block_props.sv
test/basic_block_tb.sv
